/* astro_pkg.sv */
package astro_pkg;

	// ==============================
	// Game selection
	// ==============================

	// Loader game numbers, gaps are dropped titles
	typedef enum logic [7:0] {
		GAME_NONE     = 8'd0,
		GAME_SPACEZAP = 8'd3,
		GAME_GORF     = 8'd4,
		GAME_WOW      = 8'd5,
		GAME_ROBBY    = 8'd6
	} game_id_e;

	// One loader byte, meaning set by load index
	typedef union packed {
		game_id_e   game; // Index LOAD_IDX_GAME
		logic [7:0] dip;  // Index LOAD_IDX_DIP
	} cfg_word_u;

	// Loader index values
	localparam logic [7:0] LOAD_IDX_GAME = 8'd1;
	localparam logic [7:0] LOAD_IDX_DIP  = 8'd254;

	// ==============================
	// Switch matrix
	// ==============================

	// Column strobes from the Bally I/O chip
	localparam logic [7:0] COL_CTRL0 = 8'h01; // Coin, starts, some DIPs
	localparam logic [7:0] COL_CTRL1 = 8'h02; // Player 2 stick
	localparam logic [7:0] COL_CTRL2 = 8'h04; // Player 1 stick
	localparam logic [7:0] COL_DIP3  = 8'h08; // Straight DIP byte

	// Open bus reads high
	localparam logic [7:0] ROW_IDLE = 8'hff;

	// ==============================
	// Keyboard
	// ==============================

	// Toggle, pressed, 9 bit code
	localparam int PS2_KEY_W = 11;

endpackage

/* bally_switch_top.sv */
`timescale 1ns/1ps

module bally_switch_top #(
	parameter int LOAD_ADDR_W = 25
) (
	input  logic                             clk_sys,
	input  logic                             reset,
	// Loader
	input  logic                             load_wr,
	input  logic [7:0]                       load_index,
	input  logic [LOAD_ADDR_W-1:0]           load_addr,
	input  astro_pkg::cfg_word_u             load_data,
	// Keyboard
	input  logic [astro_pkg::PS2_KEY_W-1:0] ps2_key,
	// Digital sticks
	input  logic [15:0]                      joy0,
	input  logic [15:0]                      joy1,
	// Bally switch matrix
	input  logic [7:0]                       col_select,
	output logic [7:0]                       row_data
);

	game_cfg_if   cfg_if (); // Game and DIPs
	player_btn_if btn_if (); // Keyboard buttons

	game_config #(
		.LOAD_ADDR_W (LOAD_ADDR_W)
	) u_game_config (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load_wr    (load_wr),
		.load_index (load_index),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.cfg        (cfg_if.src)
	);

	ps2_button_decoder u_ps2_button_decoder (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ps2_key (ps2_key),
		.btn     (btn_if.kbd)
	);

	// Fully combinational read path
	switch_matrix u_switch_matrix (
		.cfg        (cfg_if.snk),
		.btn        (btn_if.matrix),
		.joy0       (joy0),
		.joy1       (joy1),
		.col_select (col_select),
		.row_data   (row_data)
	);

endmodule

/* game_cfg_if.sv */
`timescale 1ns/1ps

interface game_cfg_if;
	import astro_pkg::*;

	game_id_e   game; // Active title
	logic [7:0] dip0; // Analogue options, unused for now
	logic [7:0] dip2; // Per-game bits into the rows
	logic [7:0] dip3; // Whole byte on column 08

	// Loader side
	modport src (
		output game,
		output dip0,
		output dip2,
		output dip3
	);

	// Matrix side
	modport snk (
		input game,
		input dip0,
		input dip2,
		input dip3
	);

endinterface

/* game_config.sv */
`timescale 1ns/1ps

module game_config #(
	parameter int LOAD_ADDR_W = 25 // Loader address width
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   load_wr,    // One-cycle write strobe
	input  logic [7:0]             load_index,
	input  logic [LOAD_ADDR_W-1:0] load_addr,
	input  astro_pkg::cfg_word_u   load_data,
	game_cfg_if.src                cfg
);
	import astro_pkg::*;

	game_id_e   game_q;
	logic [7:0] dip0_q;
	logic [7:0] dip2_q;
	logic [7:0] dip3_q;

	logic wr_game; // Strobe decode
	logic wr_dip;

	assign wr_game = load_wr && (load_index == LOAD_IDX_GAME);
	assign wr_dip  = load_wr && (load_index == LOAD_IDX_DIP) && (load_addr < 4);

	// ==============================
	// Game select
	// ==============================

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_q <= GAME_NONE;
		end else if (wr_game) begin
			case (load_data.game)
				GAME_SPACEZAP, GAME_GORF, GAME_WOW, GAME_ROBBY:
					game_q <= load_data.game;
				default: game_q <= GAME_NONE; // Dropped or bad titles
			endcase
		end
	end

	// ==============================
	// DIP bytes
	// ==============================

	// Byte 1 only fed the dropped trackball game
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dip0_q <= 8'h00;
			dip2_q <= 8'h00;
			dip3_q <= 8'h00;
		end else if (wr_dip) begin
			case (load_addr[1:0])
				2'd0: dip0_q <= load_data.dip;
				2'd2: dip2_q <= load_data.dip;
				2'd3: dip3_q <= load_data.dip;
				default: ; // Byte 1 dropped
			endcase
		end
	end

	assign cfg.game = game_q;
	assign cfg.dip0 = dip0_q;
	assign cfg.dip2 = dip2_q;
	assign cfg.dip3 = dip3_q;

	// Matrix relies on one of five known titles
	a_game_legal: assert property (@(posedge clk_sys) disable iff (reset)
		cfg.game inside {GAME_NONE, GAME_SPACEZAP, GAME_GORF, GAME_WOW, GAME_ROBBY})
		else $error("game register holds illegal value %0h", cfg.game);

endmodule

/* player_btn_if.sv */
`timescale 1ns/1ps

interface player_btn_if;

	// Shared cabinet buttons
	logic start1;
	logic start2;
	logic coin;

	// Player 1
	logic p1_up, p1_down, p1_left, p1_right;
	logic p1_fire1, p1_fire2;

	// Player 2
	logic p2_up, p2_down, p2_left, p2_right;
	logic p2_fire1, p2_fire2;

	modport kbd (
		output start1, start2, coin,
		output p1_up, p1_down, p1_left, p1_right, p1_fire1, p1_fire2,
		output p2_up, p2_down, p2_left, p2_right, p2_fire1, p2_fire2
	);

	modport matrix (
		input start1, start2, coin,
		input p1_up, p1_down, p1_left, p1_right, p1_fire1, p1_fire2,
		input p2_up, p2_down, p2_left, p2_right, p2_fire1, p2_fire2
	);

endinterface

/* project.f */
+incdir+.
astro_pkg.sv
game_cfg_if.sv
player_btn_if.sv
game_config.sv
ps2_button_decoder.sv
switch_matrix.sv
bally_switch_top.sv
tb_bally_switch.sv

/* ps2_button_decoder.sv */
`timescale 1ns/1ps

module ps2_button_decoder (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic [astro_pkg::PS2_KEY_W-1:0] ps2_key,
	player_btn_if.kbd                        btn
);
	import astro_pkg::*;

	logic       toggle_q; // Last seen toggle
	logic       key_event;
	logic       pressed;
	logic [8:0] code;

	assign pressed   = ps2_key[9];
	assign code      = ps2_key[8:0];
	assign key_event = ps2_key[PS2_KEY_W-1] != toggle_q; // Any flip is a new key

	// ==============================
	// Key state registers
	// ==============================

	// Function row keys
	logic f1_q, f2_q, f3_q;
	// Arcade panel style keys
	logic k1_q, k2_q, k5_q;
	// Player 1 cursor block
	logic p1_up_q, p1_down_q, p1_left_q, p1_right_q;
	logic p1_fire1_q, p1_fire2_q;
	// Player 2 letter cluster
	logic p2_up_q, p2_down_q, p2_left_q, p2_right_q;
	logic p2_fire1_q, p2_fire2_q;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q   <= 1'b0;
			f1_q       <= 1'b0;
			f2_q       <= 1'b0;
			f3_q       <= 1'b0;
			k1_q       <= 1'b0;
			k2_q       <= 1'b0;
			k5_q       <= 1'b0;
			p1_up_q    <= 1'b0;
			p1_down_q  <= 1'b0;
			p1_left_q  <= 1'b0;
			p1_right_q <= 1'b0;
			p1_fire1_q <= 1'b0;
			p1_fire2_q <= 1'b0;
			p2_up_q    <= 1'b0;
			p2_down_q  <= 1'b0;
			p2_left_q  <= 1'b0;
			p2_right_q <= 1'b0;
			p2_fire1_q <= 1'b0;
			p2_fire2_q <= 1'b0;
		end else begin
			toggle_q <= ps2_key[PS2_KEY_W-1];
			if (key_event) begin
				casez (code)
					// Arrows ignore the extended bit
					9'b?_0111_0101: p1_up_q    <= pressed;
					9'b?_0111_0010: p1_down_q  <= pressed;
					9'b?_0110_1011: p1_left_q  <= pressed;
					9'b?_0111_0100: p1_right_q <= pressed;
					9'h014: p1_fire1_q <= pressed; // Ctrl
					9'h029: p1_fire2_q <= pressed; // Space
					9'h005: f1_q <= pressed;
					9'h006: f2_q <= pressed;
					9'h004: f3_q <= pressed;
					9'h016: k1_q <= pressed;
					9'h01e: k2_q <= pressed;
					9'h02e: k5_q <= pressed;
					9'h02d: p2_up_q    <= pressed; // R
					9'h02b: p2_down_q  <= pressed; // F
					9'h023: p2_left_q  <= pressed; // D
					9'h034: p2_right_q <= pressed; // G
					9'h01c: p2_fire1_q <= pressed; // A
					9'h01b: p2_fire2_q <= pressed; // S
					default: ; // Unmapped key
				endcase
			end
		end
	end

	// Doubled keys share one output
	assign btn.start1 = f1_q | k1_q;
	assign btn.start2 = f2_q | k2_q;
	assign btn.coin   = f3_q | k5_q;

	assign btn.p1_up    = p1_up_q;
	assign btn.p1_down  = p1_down_q;
	assign btn.p1_left  = p1_left_q;
	assign btn.p1_right = p1_right_q;
	assign btn.p1_fire1 = p1_fire1_q;
	assign btn.p1_fire2 = p1_fire2_q;
	assign btn.p2_up    = p2_up_q;
	assign btn.p2_down  = p2_down_q;
	assign btn.p2_left  = p2_left_q;
	assign btn.p2_right = p2_right_q;
	assign btn.p2_fire1 = p2_fire1_q;
	assign btn.p2_fire2 = p2_fire2_q;

	// An X on the toggle would fake a stream of events
	a_key_known: assert property (@(posedge clk_sys) disable iff (reset)
		!$isunknown(ps2_key))
		else $error("ps2_key has unknown bits");

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the switch matrix testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_bally_switch -f project.f -o sim_bally

./obj_dir/sim_bally > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "Run failed"
	exit 1
fi
grep -q "Simulation finished: PASS" sim.log
echo "Run passed"

/* switch_matrix.sv */
`timescale 1ns/1ps

module switch_matrix (
	game_cfg_if.snk      cfg,
	player_btn_if.matrix btn,
	input  logic [15:0]  joy0,       // Player 1 stick plus cabinet buttons
	input  logic [15:0]  joy1,       // Player 2 stick
	input  logic [7:0]   col_select, // One-hot column strobe
	output logic [7:0]   row_data
);
	import astro_pkg::*;

	// ==============================
	// Keyboard and stick merge
	// ==============================

	logic s1, s2, c;
	logic u1, d1, l1, r1, f1, fb1;
	logic u2, d2, l2, r2, f2, fb2;

	assign s1 = btn.start1 | joy0[6];
	assign s2 = btn.start2 | joy0[7];
	assign c  = btn.coin   | joy0[8];

	assign u1  = btn.p1_up    | joy0[3];
	assign d1  = btn.p1_down  | joy0[2];
	assign l1  = btn.p1_left  | joy0[1];
	assign r1  = btn.p1_right | joy0[0];
	assign f1  = btn.p1_fire1 | joy0[4];
	assign fb1 = btn.p1_fire2 | joy0[5];

	assign u2  = btn.p2_up    | joy1[3];
	assign d2  = btn.p2_down  | joy1[2];
	assign l2  = btn.p2_left  | joy1[1];
	assign r2  = btn.p2_right | joy1[0];
	assign f2  = btn.p2_fire1 | joy1[4];
	assign fb2 = btn.p2_fire2 | joy1[5];

	// Active low stick bits shared by all four titles
	logic [4:0] stick1_n;
	logic [4:0] stick2_n;

	assign stick1_n = {~f1, ~r1, ~l1, ~d1, ~u1};
	assign stick2_n = {~f2, ~r2, ~l2, ~d2, ~u2};

	// ==============================
	// Per-game row tables
	// ==============================

	logic [7:0] row_c0; // Column 01
	logic [7:0] row_c1; // Column 02
	logic [7:0] row_c2; // Column 04

	// Speech status bit is tied high
	always_comb begin
		case (cfg.game)
			GAME_SPACEZAP: begin
				row_c0 = {2'b11, ~s2, ~s1, cfg.dip2[1], 1'b1, ~c, 1'b1};
				row_c1 = {3'b111, stick2_n};
				row_c2 = {2'b11, cfg.dip2[0], stick1_n};
			end
			GAME_GORF: begin
				row_c0 = {1'b0, cfg.dip2[0], ~s2, ~s1, 1'b1, cfg.dip2[1], ~c, 1'b1};
				row_c1 = {3'b001, stick2_n};
				row_c2 = {3'b101, stick1_n};
			end
			GAME_WOW: begin
				// Second button passes through uninverted
				row_c0 = {cfg.dip2[2], ~s2, ~s1, 1'b1, cfg.dip2[1], 1'b1, ~c, 1'b1};
				row_c1 = {2'b11, ~f2, fb2, ~r2, ~l2, ~d2, ~u2};
				row_c2 = {2'b11, ~f1, fb1, ~r1, ~l1, ~d1, ~u1};
			end
			GAME_ROBBY: begin
				row_c0 = {1'b0, ~s2, ~s1, 1'b1, cfg.dip2[1], 1'b1, ~c, 1'b1};
				row_c1 = {2'b11, ~f2, 1'b1, ~r2, ~l2, ~d2, ~u2};
				row_c2 = {2'b11, ~f1, 1'b1, ~r1, ~l1, ~d1, ~u1};
			end
			default: begin // No game loaded
				row_c0 = ROW_IDLE;
				row_c1 = ROW_IDLE;
				row_c2 = ROW_IDLE;
			end
		endcase
	end

	// ==============================
	// Column decode
	// ==============================

	always_comb begin
		case (col_select)
			COL_CTRL0: row_data = row_c0;
			COL_CTRL1: row_data = row_c1;
			COL_CTRL2: row_data = row_c2;
			COL_DIP3:  row_data = cfg.dip3; // Same for every title
			default:   row_data = ROW_IDLE;
		endcase
	end

endmodule

/* tb_util.svh */
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// ==============================
// Random source
// ==============================

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1); // One step per bit
		v = {v[30:0], lfsr_q[0]};
	end
	return v;
endfunction

// ==============================
// Expected row byte
// ==============================

function automatic logic [7:0] expected_row(input game_id_e g, input logic [7:0] d2,
		input logic [7:0] d3, input logic [17:0] k, input logic [15:0] j0,
		input logic [15:0] j1, input logic [7:0] col);
	logic [5:0] p1;  // R L D U F FB, active high
	logic [5:0] p2;
	logic [2:0] cab; // Start1, start2, coin
	logic [4:0] n1;  // F R L D U, active low
	logic [4:0] n2;
	logic [7:0] c0, c1, c2;
	p1  = j0[5:0] | k[5:0];
	p2  = j1[5:0] | k[17:12];
	cab = j0[8:6] | {k[10] | k[11], k[8] | k[9], k[6] | k[7]}; // Doubled keys
	n1  = ~{p1[4], p1[0], p1[1], p1[2], p1[3]};
	n2  = ~{p2[4], p2[0], p2[1], p2[2], p2[3]};
	case (g)
		GAME_SPACEZAP: begin
			c0 = {2'b11, ~cab[1], ~cab[0], d2[1], 1'b1, ~cab[2], 1'b1};
			c1 = {3'b111, n2};
			c2 = {2'b11, d2[0], n1};
		end
		GAME_GORF: begin
			c0 = {1'b0, d2[0], ~cab[1], ~cab[0], 1'b1, d2[1], ~cab[2], 1'b1};
			c1 = {3'b001, n2};
			c2 = {3'b101, n1};
		end
		GAME_WOW: begin // FB not inverted
			c0 = {d2[2], ~cab[1], ~cab[0], 1'b1, d2[1], 1'b1, ~cab[2], 1'b1};
			c1 = {2'b11, n2[4], p2[5], n2[3:0]};
			c2 = {2'b11, n1[4], p1[5], n1[3:0]};
		end
		GAME_ROBBY: begin
			c0 = {1'b0, ~cab[1], ~cab[0], 1'b1, d2[1], 1'b1, ~cab[2], 1'b1};
			c1 = {2'b11, n2[4], 1'b1, n2[3:0]};
			c2 = {2'b11, n1[4], 1'b1, n1[3:0]};
		end
		default: begin
			c0 = 8'hff;
			c1 = 8'hff;
			c2 = 8'hff;
		end
	endcase
	case (col)
		COL_CTRL0: return c0;
		COL_CTRL1: return c1;
		COL_CTRL2: return c2;
		COL_DIP3:  return d3; // Any game
		default:   return 8'hff;
	endcase
endfunction

// ==============================
// Loader and key drivers
// ==============================

// Polls the model event counters until the event lands
task automatic await_taken(input bit from_key, input int unsigned start, input string what);
	int guard;
	guard = 0;
	while (((from_key ? key_cnt : load_cnt) == start) && guard < WAIT_LIMIT) begin
		@(posedge clk_sys);
		guard++;
	end
	if ((from_key ? key_cnt : load_cnt) == start) begin
		$display("Timeout: %s was not taken within %0d cycles", what, WAIT_LIMIT);
		report_failure();
	end
endtask

task automatic load_write(input logic [7:0] idx, input logic [ADDR_W-1:0] addr,
		input logic [7:0] data);
	int unsigned start;
	start = load_cnt;
	@(posedge clk_sys);
	load_wr    <= 1'b1;
	load_index <= idx;
	load_addr  <= addr;
	load_data  <= data;
	@(posedge clk_sys);
	load_wr <= 1'b0; // One-cycle strobe
	await_taken(1'b0, start, "loader write");
endtask

// New key event by flipping bit 10
task automatic send_key(input logic pressed, input logic [8:0] code);
	int unsigned start;
	start = key_cnt;
	@(posedge clk_sys);
	ps2_key <= {~ps2_key[PS2_KEY_W-1], pressed, code};
	await_taken(1'b1, start, "PS/2 key event");
endtask

`endif

/* tb_bally_switch.sv */
`timescale 1ns/1ps

module tb_bally_switch;
	import astro_pkg::*;

	localparam int ADDR_W          = 25;
	localparam int WAIT_LIMIT      = 16;    // Cycles any wait may take
	localparam logic [4:0] NO_SLOT = 5'd31; // Unmapped code

	logic                 clk_sys = 1'b0;
	logic                 reset;
	logic                 load_wr;
	logic [7:0]           load_index;
	logic [ADDR_W-1:0]    load_addr;
	logic [7:0]           load_data;
	logic [PS2_KEY_W-1:0] ps2_key;
	logic [15:0]          joy0;
	logic [15:0]          joy1;
	logic [7:0]           col_select;
	logic [7:0]           row_data;

	logic [31:0] lfsr_q = 32'hf407_8c2d;

	// Reference model
	game_id_e    game_m;
	logic [7:0]  dip2_m;
	logic [7:0]  dip3_m;
	logic [17:0] keys_m;   // Key slots in joystick bit order per player
	logic        toggle_m;
	logic [4:0]  slot_m;
	int unsigned load_cnt = 0; // Loader writes seen
	int unsigned key_cnt  = 0; // Key events seen
	logic [7:0]  exp_row;

	`include "tb_util.svh"

	bally_switch_top #(
		.LOAD_ADDR_W (ADDR_W)
	) u_bally_switch_top (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load_wr    (load_wr),
		.load_index (load_index),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.ps2_key    (ps2_key),
		.joy0       (joy0),
		.joy1       (joy1),
		.col_select (col_select),
		.row_data   (row_data)
	);

	always #20 clk_sys = ~clk_sys; // 40 ns period

	// ==============================
	// Reference model
	// ==============================

	function automatic logic [4:0] key_slot(input logic [8:0] code);
		if (code[7:0] == 8'h74) return 5'd0; // Arrows match either bit 8
		if (code[7:0] == 8'h6b) return 5'd1;
		if (code[7:0] == 8'h72) return 5'd2;
		if (code[7:0] == 8'h75) return 5'd3;
		case (code)
			9'h014: return 5'd4;
			9'h029: return 5'd5;
			9'h005: return 5'd6;
			9'h016: return 5'd7;
			9'h006: return 5'd8;
			9'h01e: return 5'd9;
			9'h004: return 5'd10;
			9'h02e: return 5'd11;
			9'h034: return 5'd12;
			9'h023: return 5'd13;
			9'h02b: return 5'd14;
			9'h02d: return 5'd15;
			9'h01c: return 5'd16;
			9'h01b: return 5'd17;
			default: return NO_SLOT;
		endcase
	endfunction

	assign slot_m = key_slot(ps2_key[8:0]);

	always @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_m   <= GAME_NONE;
			dip2_m   <= 8'h00;
			dip3_m   <= 8'h00;
			keys_m   <= '0;
			toggle_m <= 1'b0;
		end else begin
			toggle_m <= ps2_key[PS2_KEY_W-1];
			if (load_wr) begin
				load_cnt <= load_cnt + 1;
				if (load_index == LOAD_IDX_GAME) begin
					game_m <= (load_data inside {8'd3, 8'd4, 8'd5, 8'd6}) ?
						game_id_e'(load_data) : GAME_NONE;
				end else if (load_index == LOAD_IDX_DIP && load_addr == 2) begin
					dip2_m <= load_data;
				end else if (load_index == LOAD_IDX_DIP && load_addr == 3) begin
					dip3_m <= load_data;
				end
			end
			if (ps2_key[PS2_KEY_W-1] != toggle_m) begin // Toggle flip
				key_cnt <= key_cnt + 1;
				if (slot_m != NO_SLOT) keys_m[slot_m] <= ps2_key[9];
			end
		end
	end

	always_comb exp_row = expected_row(game_m, dip2_m, dip3_m, keys_m, joy0, joy1, col_select);

	a_row_matches: assert property (@(posedge clk_sys) disable iff (reset) row_data == exp_row)
		else begin
			$display("[ERROR] row_data=%h expected=%h col_select=%h",
				$sampled(row_data), $sampled(exp_row), $sampled(col_select));
			$display("Simulation finished: FAIL");
			$fatal(1);
		end

	task automatic report_failure();
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
		end
	endtask

	// Every strobe plus a few undriven ones
	task automatic sweep_columns();
		logic [7:0] cols [8];
		cols = '{COL_CTRL0, COL_CTRL1, COL_CTRL2, COL_DIP3, 8'h00, 8'h10, 8'h80, 8'h03};
		for (int i = 0; i < 8; i++) begin
			@(posedge clk_sys);
			col_select <= cols[i];
		end
		@(posedge clk_sys);
	endtask

	// ==============================
	// Stimulus
	// ==============================

	initial begin
		logic [7:0] games [4];
		logic [8:0] codes [18];
		games = '{GAME_SPACEZAP, GAME_GORF, GAME_WOW, GAME_ROBBY};
		codes = '{9'h074, 9'h06b, 9'h072, 9'h075, 9'h014, 9'h029, 9'h005, 9'h016, 9'h006,
			9'h01e, 9'h004, 9'h02e, 9'h034, 9'h023, 9'h02b, 9'h02d, 9'h01c, 9'h01b};
		reset      = 1'b1;
		load_wr    = 1'b0;
		load_index = 8'h00;
		load_addr  = '0;
		load_data  = 8'h00;
		ps2_key    = '0;
		joy0       = 16'h0000;
		joy1       = 16'h0000;
		col_select = 8'h00;
		idle_cycles(4);
		reset <= 1'b0;
		sweep_columns(); // Reset rows

		// Byte 3 first so stray low byte writes land last
		for (int a = 0; a < 4; a++) begin
			load_write(LOAD_IDX_DIP, ADDR_W'(3 - a), 8'(rand_bits(8)));
		end
		foreach (games[g]) begin
			load_write(LOAD_IDX_GAME, '0, games[g]);
			sweep_columns();
		end
		load_write(LOAD_IDX_GAME, '0, 8'd2); // Dropped titles
		sweep_columns();
		load_write(LOAD_IDX_GAME, '0, 8'd7);
		sweep_columns();
		load_write(LOAD_IDX_GAME, '0, GAME_GORF);
		load_write(8'd5, ADDR_W'(3), 8'h06); // Foreign index
		load_write(LOAD_IDX_DIP, ADDR_W'(6), ~dip2_m);
		load_write(LOAD_IDX_DIP, ADDR_W'(32'h0100_0003), ~dip3_m); // High bit set
		sweep_columns();

		// Sticks alone
		foreach (games[g]) begin
			load_write(LOAD_IDX_GAME, '0, games[g]);
			for (int n = 0; n < 12; n++) begin
				@(posedge clk_sys);
				joy0 <= 16'(rand_bits(9));
				joy1 <= 16'(rand_bits(6));
				sweep_columns();
			end
		end

		// Keys, first alone, then over random sticks
		load_write(LOAD_IDX_GAME, '0, GAME_WOW);
		for (int p = 0; p < 2; p++) begin
			foreach (codes[i]) begin
				@(posedge clk_sys);
				joy0 <= (p == 0) ? 16'h0000 : 16'(rand_bits(9));
				joy1 <= (p == 0) ? 16'h0000 : 16'(rand_bits(6));
				send_key(1'b1, codes[i]);
				sweep_columns();
				send_key(1'b0, codes[i]);
				sweep_columns();
			end
		end
		@(posedge clk_sys);
		joy0 <= 16'h0000;
		joy1 <= 16'h0000;
		for (int i = 0; i < 4; i++) begin // Extended arrows
			send_key(1'b1, {1'b1, codes[i][7:0]});
			sweep_columns();
			send_key(1'b0, {1'b1, codes[i][7:0]});
		end

		// Pressed bit flips with toggle held
		send_key(1'b1, 9'h014);
		@(posedge clk_sys);
		ps2_key <= {ps2_key[PS2_KEY_W-1], 1'b0, 9'h014};
		sweep_columns();
		send_key(1'b0, 9'h014);
		send_key(1'b1, 9'h01a);
		send_key(1'b1, 9'h114); // Ctrl only without bit 8
		sweep_columns();

		// Reset with state loaded
		load_write(LOAD_IDX_DIP, ADDR_W'(3), 8'ha5);
		send_key(1'b1, 9'h016);
		send_key(1'b1, 9'h075);
		@(posedge clk_sys);
		reset   <= 1'b1;
		ps2_key <= '0; // No stale event after reset
		idle_cycles(4);
		reset <= 1'b0;
		sweep_columns();
		load_write(LOAD_IDX_GAME, '0, GAME_WOW); // Cleared keys and DIPs show here
		sweep_columns();

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
